/* build.f */
+incdir+.
ps_bridge_pkg.sv
ps_mem.sv
ps_reqhandler.sv
ps_bridge_top.sv
ps_bridge_assert.sv
ps_bridge_checker.sv
tb_ps_bridge.sv

/* Bender.yml */
package:
  name: ps_bridge

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ps_bridge_pkg.sv
      - ps_mem.sv
      - ps_reqhandler.sv
      - ps_bridge_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - ps_bridge_assert.sv
      - ps_bridge_checker.sv
      - tb_ps_bridge.sv

/* tb_ps_bridge.sv */
`timescale 1ns/1ns
`include "ps_bridge_defines.svh"

module tb_ps_bridge;

	import ps_bridge_pkg::*;

	localparam int N_WR      = 24;
	localparam int N_RD      = 28;
	localparam int MAX_STALL = 6;
	localparam int LIMIT     = (N_WR + N_RD) * (`PS_MEM_LAT + 2 + MAX_STALL) * 2;

	logic    clk = 1'b0;
	logic    rst, done;
	logic    have_windex, have_wdata, have_rindex;
	addr_t   windex_in, rindex_in;
	data_t   wdata_in;
	logic    wrsp_ready, rrsp_ready;
	logic    wrsp_valid, rrsp_valid;
	wr_rsp_t wrsp;
	rd_rsp_t rrsp;
	logic    windex_credit, wdata_credit, rindex_credit;
	int      errors, cycles;
	int      wi_used, wd_used, ri_used, wi_ret, wd_ret, ri_ret;
	int      wr_taken, rd_taken, wi_n, wd_n, ri_n;
	addr_t   w_idx [N_WR];
	data_t   w_dat [N_WR];
	addr_t   r_idx [N_RD];

	always #2 clk = ~clk;

	ps_bridge_top UUT (.*);

	ps_bridge_checker u_checker (.*);

	// Credits come back and responses are taken on the rising edge
	always @(posedge clk) begin
		if (!rst) begin
			wi_ret += int'(windex_credit);
			wd_ret += int'(wdata_credit);
			ri_ret += int'(rindex_credit);
			wr_taken += int'(wrsp_valid && wrsp_ready);
			rd_taken += int'(rrsp_valid && rrsp_ready);
		end
	end

	always @(negedge clk) begin
		if (rst) begin
			wrsp_ready = 1'b0;
			rrsp_ready = 1'b0;
		end else begin
			wrsp_ready = ($urandom % 4) != 0;
			rrsp_ready = ($urandom % 4) != 0;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout after %0d cycles: %0d of %0d writes, %0d of %0d reads done",
				cycles, wr_taken, N_WR, rd_taken, N_RD);
			$display("sim failed");
			$finish;
		end
	end

	function automatic addr_t pick_index();
		if ($urandom % 6 == 0)
			return addr_t'(`PS_MEM_WORDS + $urandom % (256 - `PS_MEM_WORDS));
		return addr_t'($urandom % `PS_MEM_WORDS);
	endfunction

	initial begin
		void'($urandom(32'ha2b8ef58));
		{have_windex, have_wdata, have_rindex, done} = '0;
		windex_in = '0;
		rindex_in = '0;
		wdata_in = '0;
		wrsp_ready = 1'b0;
		rrsp_ready = 1'b0;
		{wi_used, wd_used, ri_used, wi_ret, wd_ret, ri_ret} = '0;
		{wr_taken, rd_taken, wi_n, wd_n, ri_n, cycles} = '0;
		rst = 1'b1;
		for (int i = 0; i < N_WR; i++) begin
			w_idx[i] = pick_index();
			w_dat[i] = $urandom;
		end
		for (int i = 0; i < N_RD; i++)
			r_idx[i] = (i < N_WR) ? w_idx[i] : addr_t'($urandom % `PS_MEM_WORDS);
		repeat (4) @(posedge clk);
		@(negedge clk) rst = 1'b0;

		// Index and data go out independently, so they skew at random
		while (wi_n < N_WR || wd_n < N_WR) begin
			@(negedge clk);
			have_windex = 1'b0;
			have_wdata = 1'b0;
			if (wi_n < N_WR && wi_used - wi_ret < `PS_REQ_BUF && $urandom % 2) begin
				have_windex = 1'b1;
				windex_in = w_idx[wi_n];
				wi_n++;
				wi_used++;
			end
			if (wd_n < N_WR && wd_used - wd_ret < `PS_REQ_BUF && $urandom % 2) begin
				have_wdata = 1'b1;
				wdata_in = w_dat[wd_n];
				wd_n++;
				wd_used++;
			end
		end
		@(negedge clk);
		have_windex = 1'b0;
		have_wdata = 1'b0;
		while (wr_taken < N_WR)
			@(negedge clk);

		// Reads start only once every write has finished
		while (ri_n < N_RD) begin
			@(negedge clk);
			have_rindex = 1'b0;
			if (ri_used - ri_ret < `PS_REQ_BUF && $urandom % 2) begin
				have_rindex = 1'b1;
				rindex_in = r_idx[ri_n];
				ri_n++;
				ri_used++;
			end
		end
		@(negedge clk) have_rindex = 1'b0;
		while (rd_taken < N_RD)
			@(negedge clk);

		repeat (2) @(negedge clk);
		done = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		$display("Errors: checker %0d, assertions %0d",
			errors, UUT.u_reqhandler.u_assert.fail_cnt);
		if (errors == 0 && UUT.u_reqhandler.u_assert.fail_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* ps_bridge_checker.sv */
`timescale 1ns/1ns
`include "ps_bridge_defines.svh"

module ps_bridge_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   done,
	input  logic                   have_windex,
	input  logic                   have_wdata,
	input  logic                   have_rindex,
	input  ps_bridge_pkg::addr_t   windex_in,
	input  ps_bridge_pkg::addr_t   rindex_in,
	input  ps_bridge_pkg::data_t   wdata_in,
	input  logic                   wrsp_valid,
	input  logic                   wrsp_ready,
	input  ps_bridge_pkg::wr_rsp_t wrsp,
	input  logic                   rrsp_valid,
	input  logic                   rrsp_ready,
	input  ps_bridge_pkg::rd_rsp_t rrsp,
	input  logic                   windex_credit,
	input  logic                   wdata_credit,
	input  logic                   rindex_credit,
	output int                     errors
);

	import ps_bridge_pkg::*;

	data_t   shadow [`PS_MEM_WORDS];
	addr_t   wi_pend[$];
	data_t   wd_pend[$];
	wr_rsp_t exp_wr[$];
	rd_rsp_t exp_rd[$];
	wr_rsp_t exp_w, prev_w;
	rd_rsp_t exp_r, prev_r;
	logic    w_hold, r_hold, checked;
	int      wi_cr, wd_cr, ri_cr;

	// Expected read data: last paired write, or zero past the end
	function automatic data_t ps_ref_read(input addr_t idx);
		return (idx < `PS_MEM_WORDS) ? shadow[idx] : '0;
	endfunction

	function automatic resp_t ps_ref_resp(input addr_t idx);
		return (idx < `PS_MEM_WORDS) ? RESP_OKAY : RESP_SLVERR;
	endfunction

	initial begin
		foreach (shadow[i])
			shadow[i] = '0;
		errors = 0;
		checked = 1'b0;
		w_hold = 1'b0;
		r_hold = 1'b0;
		wi_cr = `PS_REQ_BUF;
		wd_cr = `PS_REQ_BUF;
		ri_cr = `PS_REQ_BUF;
	end

	always @(posedge clk) begin
		if (!rst) begin
			if (have_windex)
				wi_pend.push_back(windex_in);
			if (have_wdata)
				wd_pend.push_back(wdata_in);
			// Index and data pair strictly in arrival order
			while (wi_pend.size() > 0 && wd_pend.size() > 0) begin
				exp_w.addr = wi_pend.pop_front();
				exp_w.resp = ps_ref_resp(exp_w.addr);
				exp_wr.push_back(exp_w);
				if (exp_w.addr < `PS_MEM_WORDS)
					shadow[exp_w.addr] = wd_pend.pop_front();
				else
					void'(wd_pend.pop_front());
			end
			if (have_rindex) begin
				exp_r.addr = rindex_in;
				exp_r.data = ps_ref_read(rindex_in);
				exp_r.resp = ps_ref_resp(rindex_in);
				exp_rd.push_back(exp_r);
			end

			// Payload must not move while waiting for ready
			if (w_hold && wrsp_valid && wrsp !== prev_w) begin
				$display("MISMATCH at %0t: write response changed while stalled", $time);
				errors++;
			end
			if (r_hold && rrsp_valid && rrsp !== prev_r) begin
				$display("MISMATCH at %0t: read response changed while stalled", $time);
				errors++;
			end
			w_hold = wrsp_valid && !wrsp_ready;
			r_hold = rrsp_valid && !rrsp_ready;
			prev_w = wrsp;
			prev_r = rrsp;

			if (wrsp_valid && wrsp_ready) begin
				if (exp_wr.size() == 0) begin
					$display("Unexpected write response at %0t with no write pending", $time);
					errors++;
				end else begin
					exp_w = exp_wr.pop_front();
					if (wrsp !== exp_w) begin
						$display("MISMATCH at %0t: write rsp addr %0h resp %0d, expected %0h %0d",
							$time, wrsp.addr, wrsp.resp, exp_w.addr, exp_w.resp);
						errors++;
					end
				end
			end
			if (rrsp_valid && rrsp_ready) begin
				if (exp_rd.size() == 0) begin
					$display("Unexpected read response at %0t with no read pending", $time);
					errors++;
				end else begin
					exp_r = exp_rd.pop_front();
					if (rrsp !== exp_r) begin
						$display("MISMATCH at %0t: read rsp %0h/%h/%0d, expected %0h/%h/%0d",
							$time, rrsp.addr, rrsp.data, rrsp.resp,
							exp_r.addr, exp_r.data, exp_r.resp);
						errors++;
					end
				end
			end

			// Each credit goes back in the cycle its response is taken
			if (windex_credit !== (wrsp_valid && wrsp_ready)
				|| wdata_credit !== (wrsp_valid && wrsp_ready)
				|| rindex_credit !== (rrsp_valid && rrsp_ready)) begin
				$display("Credit pulse out of step with a response handshake at %0t", $time);
				errors++;
			end

			wi_cr = wi_cr - int'(have_windex) + int'(windex_credit);
			wd_cr = wd_cr - int'(have_wdata) + int'(wdata_credit);
			ri_cr = ri_cr - int'(have_rindex) + int'(rindex_credit);
			if (wi_cr < 0 || wd_cr < 0 || ri_cr < 0) begin
				$display("Host sent a request without a credit at %0t", $time);
				errors++;
			end

			if (done && !checked) begin
				checked = 1'b1;
				if (exp_wr.size() != 0 || exp_rd.size() != 0) begin
					$display("Responses never arrived: %0d writes, %0d reads",
						exp_wr.size(), exp_rd.size());
					errors++;
				end
				if (wi_cr != `PS_REQ_BUF || wd_cr != `PS_REQ_BUF || ri_cr != `PS_REQ_BUF) begin
					$display("Credits not all returned: index %0d, data %0d, read %0d",
						wi_cr, wd_cr, ri_cr);
					errors++;
				end
			end
		end
	end

endmodule

/* ps_bridge_assert.sv */
`timescale 1ns/1ns
`include "ps_bridge_defines.svh"

module ps_bridge_assert #(
	parameter int DEPTH = `PS_REQ_BUF,
	parameter int CNTW  = 3
) (
	input logic            clk,
	input logic            rst,
	input logic            have_windex,
	input logic            have_wdata,
	input logic            have_rindex,
	input logic            wrsp_valid,
	input logic            wrsp_ready,
	input logic            rrsp_valid,
	input logic            rrsp_ready,
	input logic            windex_credit,
	input logic            wdata_credit,
	input logic            rindex_credit,
	input logic            mem_wr_req,
	input logic            wcomplete,
	input logic [CNTW-1:0] wi_cnt,
	input logic [CNTW-1:0] wd_cnt,
	input logic [CNTW-1:0] ri_cnt
);

	int   fail_cnt = 0;
	logic w_out; // A write is in flight at the memory

	always_ff @(posedge clk) begin
		if (rst)
			w_out <= 1'b0;
		else if (mem_wr_req)
			w_out <= 1'b1;
		else if (wcomplete)
			w_out <= 1'b0;
	end

	// A returned credit must free a slot that really holds an entry
	a_wcredit: assert property (@(posedge clk) disable iff (rst)
		(windex_credit || wdata_credit) |-> (wi_cnt != '0 && wd_cnt != '0))
		else begin
			$error("write credit returned for an empty write queue");
			fail_cnt++;
		end

	a_rcredit: assert property (@(posedge clk) disable iff (rst)
		rindex_credit |-> (ri_cnt != '0))
		else begin
			$error("read credit returned for an empty read queue");
			fail_cnt++;
		end

	a_wr_one: assert property (@(posedge clk) disable iff (rst) mem_wr_req |-> !w_out)
		else begin
			$error("second write request while one is outstanding");
			fail_cnt++;
		end

	a_wvalid: assert property (@(posedge clk) disable iff (rst)
		(wrsp_valid && !wrsp_ready) |=> wrsp_valid)
		else begin
			$error("write response dropped before it was taken");
			fail_cnt++;
		end

	a_rvalid: assert property (@(posedge clk) disable iff (rst)
		(rrsp_valid && !rrsp_ready) |=> rrsp_valid)
		else begin
			$error("read response dropped before it was taken");
			fail_cnt++;
		end

	a_full: assert property (@(posedge clk) disable iff (rst)
		!((have_windex && wi_cnt == CNTW'(DEPTH)) || (have_wdata && wd_cnt == CNTW'(DEPTH))
			|| (have_rindex && ri_cnt == CNTW'(DEPTH))))
		else begin
			$error("request pulse into a full queue");
			fail_cnt++;
		end

endmodule

bind ps_reqhandler ps_bridge_assert #(
	.DEPTH (REQ_BUFFER_SZ),
	.CNTW  (CNTW)
) u_assert (
	.clk           (clk),
	.rst           (rst),
	.have_windex   (have_windex),
	.have_wdata    (have_wdata),
	.have_rindex   (have_rindex),
	.wrsp_valid    (wrsp_valid),
	.wrsp_ready    (wrsp_ready),
	.rrsp_valid    (rrsp_valid),
	.rrsp_ready    (rrsp_ready),
	.windex_credit (windex_credit),
	.wdata_credit  (wdata_credit),
	.rindex_credit (rindex_credit),
	.mem_wr_req    (mem_wr_req),
	.wcomplete     (wcomplete),
	.wi_cnt        (wi_cnt),
	.wd_cnt        (wd_cnt),
	.ri_cnt        (ri_cnt)
);

/* ps_bridge_top.sv */
`timescale 1ns/1ns
`include "ps_bridge_defines.svh"

module ps_bridge_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    have_windex,
	input  logic                    have_wdata,
	input  logic                    have_rindex,
	input  ps_bridge_pkg::addr_t    windex_in,
	input  ps_bridge_pkg::addr_t    rindex_in,
	input  ps_bridge_pkg::data_t    wdata_in,
	input  logic                    wrsp_ready,
	input  logic                    rrsp_ready,
	output logic                    wrsp_valid,
	output ps_bridge_pkg::wr_rsp_t  wrsp,
	output logic                    rrsp_valid,
	output ps_bridge_pkg::rd_rsp_t  rrsp,
	output logic                    windex_credit,
	output logic                    wdata_credit,
	output logic                    rindex_credit
);

	import ps_bridge_pkg::*;

	// Handler to memory links
	logic    mem_wr_req, mem_rd_req;
	mem_wr_t mem_wr;
	addr_t   mem_rd_addr;
	logic    wcomplete, rcomplete;
	data_t   mem_rdata;

	ps_reqhandler #(
		.REQ_BUFFER_SZ (`PS_REQ_BUF)
	) u_reqhandler (
		.clk           (clk),
		.rst           (rst),
		.have_windex   (have_windex),
		.have_wdata    (have_wdata),
		.have_rindex   (have_rindex),
		.windex_in     (windex_in),
		.rindex_in     (rindex_in),
		.wdata_in      (wdata_in),
		.wrsp_ready    (wrsp_ready),
		.rrsp_ready    (rrsp_ready),
		.wcomplete     (wcomplete),
		.rcomplete     (rcomplete),
		.rdata_in      (mem_rdata),
		.wrsp_valid    (wrsp_valid),
		.wrsp          (wrsp),
		.rrsp_valid    (rrsp_valid),
		.rrsp          (rrsp),
		.mem_wr_req    (mem_wr_req),
		.mem_wr        (mem_wr),
		.mem_rd_req    (mem_rd_req),
		.mem_rd_addr   (mem_rd_addr),
		.windex_credit (windex_credit),
		.wdata_credit  (wdata_credit),
		.rindex_credit (rindex_credit)
	);

	ps_mem #(
		.LATENCY (`PS_MEM_LAT),
		.WORDS   (`PS_MEM_WORDS)
	) u_mem (
		.clk         (clk),
		.rst         (rst),
		.mem_wr_req  (mem_wr_req),
		.mem_wr      (mem_wr),
		.mem_rd_req  (mem_rd_req),
		.mem_rd_addr (mem_rd_addr),
		.wcomplete   (wcomplete),
		.rcomplete   (rcomplete),
		.rdata       (mem_rdata)
	);

endmodule

/* ps_reqhandler.sv */
`timescale 1ns/1ns
`include "ps_bridge_defines.svh"

module ps_reqhandler #(
	parameter int REQ_BUFFER_SZ = `PS_REQ_BUF
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    have_windex,
	input  logic                    have_wdata,
	input  logic                    have_rindex,
	input  ps_bridge_pkg::addr_t    windex_in,
	input  ps_bridge_pkg::addr_t    rindex_in,
	input  ps_bridge_pkg::data_t    wdata_in,
	input  logic                    wrsp_ready,
	input  logic                    rrsp_ready,
	input  logic                    wcomplete,
	input  logic                    rcomplete,
	input  ps_bridge_pkg::data_t    rdata_in,
	output logic                    wrsp_valid,
	output ps_bridge_pkg::wr_rsp_t  wrsp,
	output logic                    rrsp_valid,
	output ps_bridge_pkg::rd_rsp_t  rrsp,
	output logic                    mem_wr_req,
	output ps_bridge_pkg::mem_wr_t  mem_wr,
	output logic                    mem_rd_req,
	output ps_bridge_pkg::addr_t    mem_rd_addr,
	output logic                    windex_credit,
	output logic                    wdata_credit,
	output logic                    rindex_credit
);

	import ps_bridge_pkg::*;

	localparam int PTRW = (REQ_BUFFER_SZ > 1) ? $clog2(REQ_BUFFER_SZ) : 1;
	localparam int CNTW = $clog2(REQ_BUFFER_SZ + 1);

	// Queue storage, filled at the tail and drained at the head
	addr_t wi_q [REQ_BUFFER_SZ];
	data_t wd_q [REQ_BUFFER_SZ];
	addr_t ri_q [REQ_BUFFER_SZ];

	logic [PTRW-1:0] wi_head, wi_tail;
	logic [PTRW-1:0] wd_head, wd_tail;
	logic [PTRW-1:0] ri_head, ri_tail;
	logic [CNTW-1:0] wi_cnt, wd_cnt, ri_cnt; // Occupancy per queue

	tx_state_t w_state, r_state;
	logic      w_pop, r_pop;

	// Circular pointer step, wraps at the queue depth
	function automatic logic [PTRW-1:0] ptr_next(input logic [PTRW-1:0] p);
		if (p == PTRW'(REQ_BUFFER_SZ - 1))
			return '0;
		return p + 1'b1;
	endfunction

	function automatic resp_t index_resp(input addr_t idx);
		return (idx < `PS_MEM_WORDS) ? RESP_OKAY : RESP_SLVERR;
	endfunction

	// A response handshake frees the head slot
	assign w_pop = wrsp_valid && wrsp_ready;
	assign r_pop = rrsp_valid && rrsp_ready;

	assign windex_credit = w_pop; // Index and data slots go back together
	assign wdata_credit  = w_pop;
	assign rindex_credit = r_pop;

	// Memory sees the queue heads; they hold until the response is taken
	assign mem_wr.addr = wi_q[wi_head];
	assign mem_wr.data = wd_q[wd_head];
	assign mem_rd_addr = ri_q[ri_head];

	always_ff @(posedge clk) begin
		if (have_windex)
			wi_q[wi_tail] <= windex_in;
		if (have_wdata)
			wd_q[wd_tail] <= wdata_in;
		if (have_rindex)
			ri_q[ri_tail] <= rindex_in;
	end

	// Pointer and occupancy bookkeeping
	always_ff @(posedge clk) begin
		if (rst) begin
			{wi_head, wi_tail, wd_head, wd_tail, ri_head, ri_tail} <= '0;
			{wi_cnt, wd_cnt, ri_cnt} <= '0;
		end else begin
			if (have_windex)
				wi_tail <= ptr_next(wi_tail);
			if (have_wdata)
				wd_tail <= ptr_next(wd_tail);
			if (have_rindex)
				ri_tail <= ptr_next(ri_tail);
			if (w_pop) begin
				wi_head <= ptr_next(wi_head);
				wd_head <= ptr_next(wd_head);
			end
			if (r_pop)
				ri_head <= ptr_next(ri_head);
			wi_cnt <= wi_cnt + CNTW'(have_windex) - CNTW'(w_pop);
			wd_cnt <= wd_cnt + CNTW'(have_wdata) - CNTW'(w_pop);
			ri_cnt <= ri_cnt + CNTW'(have_rindex) - CNTW'(r_pop);
		end
	end

	// Write FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			w_state    <= IDLE;
			mem_wr_req <= 1'b0;
			wrsp_valid <= 1'b0;
		end else begin
			mem_wr_req <= 1'b0; // Single-cycle request pulse
			case (w_state)
				IDLE: begin
					// Index and data both present at the heads
					if (wi_cnt != '0 && wd_cnt != '0) begin
						mem_wr_req <= 1'b1;
						w_state    <= ISSUE;
					end
				end
				ISSUE: begin
					if (wcomplete) begin
						wrsp_valid <= 1'b1;
						w_state    <= SEND;
					end
				end
				SEND: begin
					if (wrsp_ready) begin
						wrsp_valid <= 1'b0;
						w_state    <= IDLE;
					end
				end
				default: w_state <= IDLE;
			endcase
		end
	end

	// Read FSM, same flow as the write side
	always_ff @(posedge clk) begin
		if (rst) begin
			r_state    <= IDLE;
			mem_rd_req <= 1'b0;
			rrsp_valid <= 1'b0;
		end else begin
			mem_rd_req <= 1'b0;
			case (r_state)
				IDLE: begin
					if (ri_cnt != '0) begin
						mem_rd_req <= 1'b1;
						r_state    <= ISSUE;
					end
				end
				ISSUE: begin
					if (rcomplete) begin
						rrsp_valid <= 1'b1;
						r_state    <= SEND;
					end
				end
				SEND: begin
					if (rrsp_ready) begin
						rrsp_valid <= 1'b0;
						r_state    <= IDLE;
					end
				end
				default: r_state <= IDLE;
			endcase
		end
	end

	// Response payloads are captured on completion and held while in SEND
	always_ff @(posedge clk) begin
		if (w_state == ISSUE && wcomplete) begin
			wrsp.addr <= wi_q[wi_head];
			wrsp.resp <= index_resp(wi_q[wi_head]);
		end
		if (r_state == ISSUE && rcomplete) begin
			rrsp.addr <= ri_q[ri_head];
			rrsp.data <= rdata_in; // Memory already zeroes out-of-range reads
			rrsp.resp <= index_resp(ri_q[ri_head]);
		end
	end

endmodule

/* ps_mem.sv */
`timescale 1ns/1ns
`include "ps_bridge_defines.svh"

module ps_mem #(
	parameter int LATENCY = `PS_MEM_LAT,
	parameter int WORDS   = `PS_MEM_WORDS
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    mem_wr_req,
	input  ps_bridge_pkg::mem_wr_t  mem_wr,
	input  logic                    mem_rd_req,
	input  ps_bridge_pkg::addr_t    mem_rd_addr,
	output logic                    wcomplete,
	output logic                    rcomplete,
	output ps_bridge_pkg::data_t    rdata
);

	import ps_bridge_pkg::*;

	// Countdown width, enough to hold LATENCY-1
	localparam int CNTW = (LATENCY > 1) ? $clog2(LATENCY) : 1;

	data_t   mem_q [WORDS];
	mem_wr_t wr_q;      // Latched write request
	addr_t   rd_addr_q; // Latched read index

	logic            w_busy, r_busy;
	logic [CNTW-1:0] w_cnt, r_cnt;

	// Completion lands exactly LATENCY cycles after the request pulse
	assign wcomplete = w_busy && (w_cnt == '0);
	assign rcomplete = r_busy && (r_cnt == '0);

	// Out-of-range reads return zero
	assign rdata = (rd_addr_q < WORDS) ? mem_q[rd_addr_q] : '0;

	always_ff @(posedge clk) begin
		if (mem_wr_req)
			wr_q <= mem_wr;
		if (mem_rd_req)
			rd_addr_q <= mem_rd_addr;
	end

	// Write side
	always_ff @(posedge clk) begin
		if (rst) begin
			w_busy <= 1'b0;
			w_cnt  <= '0;
			for (int i = 0; i < WORDS; i++)
				mem_q[i] <= '0;
		end else if (mem_wr_req) begin
			w_busy <= 1'b1;
			w_cnt  <= CNTW'(LATENCY - 1);
		end else if (w_busy) begin
			if (w_cnt == '0) begin
				w_busy <= 1'b0;
				// Writes past the end are dropped
				if (wr_q.addr < WORDS)
					mem_q[wr_q.addr] <= wr_q.data;
			end else begin
				w_cnt <= w_cnt - 1'b1;
			end
		end
	end

	// Read side
	always_ff @(posedge clk) begin
		if (rst) begin
			r_busy <= 1'b0;
			r_cnt  <= '0;
		end else if (mem_rd_req) begin
			r_busy <= 1'b1;
			r_cnt  <= CNTW'(LATENCY - 1);
		end else if (r_busy) begin
			if (r_cnt == '0)
				r_busy <= 1'b0; // Data is presented with rcomplete
			else
				r_cnt <= r_cnt - 1'b1;
		end
	end

endmodule

/* ps_bridge_pkg.sv */
`include "ps_bridge_defines.svh"

package ps_bridge_pkg;

	// Word index into the internal memory
	typedef logic [`PS_ADDRW-1:0] addr_t;

	// One data word
	typedef logic [`PS_DATAW-1:0] data_t;

	// Response status returned with every write response and read data
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2; // Index outside the memory

	// Write request from the handler to the memory
	typedef struct packed {
		addr_t addr;
		data_t data;
	} mem_wr_t;

	// Write response towards the host
	typedef struct packed {
		addr_t addr;
		resp_t resp;
	} wr_rsp_t;

	// Read response towards the host
	typedef struct packed {
		addr_t addr;
		data_t data;
		resp_t resp;
	} rd_rsp_t;

	// Per-direction transaction FSM
	// IDLE waits for a queued request, ISSUE waits on the memory,
	// SEND holds the response until the host takes it
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		SEND
	} tx_state_t;

endpackage

/* ps_bridge_defines.svh */
`ifndef PS_BRIDGE_DEFINES_SVH
`define PS_BRIDGE_DEFINES_SVH

// Host side word index and data widths
`define PS_ADDRW 8
`define PS_DATAW 32

// Queue depth per request queue, also the starting credit count
`define PS_REQ_BUF 4

// Internal memory size in words
// Any index at or above this value is out of range
`define PS_MEM_WORDS 200

// Cycles from a memory request pulse to its completion strobe
`define PS_MEM_LAT 3

`endif
